//--- build.f
source/rvPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/hazardScoreboard.sv
source/issueStage.sv
source/executeStage.sv
source/coreTop.sv
verif/coreTb.sv

//--- Makefile
SIM = obj_dir/VcoreTb

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(SIM): build.f $(wildcard source/*.sv) $(wildcard verif/*.sv)
	verilator --binary --top-module coreTb -f build.f -Mdir obj_dir -o VcoreTb

# the log decides, since the simulator exits cleanly either way
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/coreTb.sv
`default_nettype none

module coreTb import rvPkg::*;
();

    localparam int stallLimit = 16;    // cycles a word may wait on instrReady
    localparam int drainLimit = 40;

    logic        clk;
    logic        nrst;
    logic        instrValid;
    instrWord    instr;
    logic        instrReady;
    logic        commitValid;
    regAddr      commitRd;
    logic [31:0] commitData;

    logic [31:0] archRegs [0:31];   // reference register state in acceptance order
    regAddr      expRd [$];
    logic [31:0] expData [$];
    int          expEdge [$];       // rising edge that accepted the word
    int          edgeCount;
    int          errorCount;
    int          commitCount;
    logic        timedOut;
    regAddr      wantRd;
    logic [31:0] wantData;
    int          wantEdge;

    coreTop coreTop_inst
    (
        .clk         (clk),
        .nrst        (nrst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitData  (commitData)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        edgeCount++;

    // RV32I result for OP and OP-IMM, alt is instruction bit 30
    function automatic logic [31:0] refResult(input logic isR, input logic [2:0] f3,
                                              input logic alt, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = (isR && alt) ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic instrWord makeR(input logic [2:0] f3, input logic alt, input regAddr rd,
                                       input regAddr rs1, input regAddr rs2);
        instrWord w;
        w.rView.funct7 = alt ? 7'b0100000 : 7'b0000000;
        w.rView.rs2    = rs2;
        w.rView.rs1    = rs1;
        w.rView.funct3 = f3;
        w.rView.rd     = rd;
        w.rView.opcode = opcodeOp;
        return w;
    endfunction

    function automatic instrWord makeI(input logic [2:0] f3, input logic [11:0] imm,
                                       input regAddr rd, input regAddr rs1);
        instrWord w;
        w.iView.imm12  = imm;
        w.iView.rs1    = rs1;
        w.iView.funct3 = f3;
        w.iView.rd     = rd;
        w.iView.opcode = opcodeOpImm;
        return w;
    endfunction

    // small values, small negatives or anything
    function automatic logic [11:0] randomImm();
        logic [11:0] v;
        case ($urandom_range(2))
            0: v = 12'($urandom_range(15));
            1: v = -12'($urandom_range(16, 1));
            default: v = 12'($urandom);
        endcase
        return v;
    endfunction

    function automatic instrWord randomWord();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        instrWord    w;
        f3  = 3'($urandom_range(7));
        alt = 1'($urandom_range(1));
        if ($urandom_range(9) < 5)
            w = makeR(f3, alt && (f3 == 3'b000 || f3 == 3'b101), 5'($urandom_range(7)),
                      5'($urandom_range(7)), 5'($urandom_range(7)));
        else
        begin
            if (f3 == 3'b001)
                imm = {7'b0, 5'($urandom)};            // slli
            else if (f3 == 3'b101)
                imm = {1'b0, alt, 5'b0, 5'($urandom)}; // srli or srai
            else
                imm = randomImm();
            w = makeI(f3, imm, 5'($urandom_range(7)), 5'($urandom_range(7)));
        end
        if ($urandom_range(19) == 0)
            w.rView.opcode = 7'b0000011;   // a load, dropped by the core
        return w;
    endfunction

    task automatic modelAccept(input instrWord word, input int acceptEdge);
        logic        isR;
        logic        isI;
        logic [31:0] b;
        logic [31:0] result;
        isR = (word.rView.opcode == opcodeOp);
        isI = (word.iView.opcode == opcodeOpImm);
        if (isR || isI)
        begin
            if (isR)
                b = archRegs[word.rView.rs2];
            else
                b = {{20{word.iView.imm12[11]}}, word.iView.imm12};
            result = refResult(isR, word.rView.funct3, word.rView.funct7[5],
                               archRegs[word.rView.rs1], b);
            if (word.rView.rd != 5'd0)
            begin
                archRegs[word.rView.rd] = result;
                expRd.push_back(word.rView.rd);
                expData.push_back(result);
                expEdge.push_back(acceptEdge);
            end
        end
    endtask

    // inputs settle before the next rising edge, so instrReady here is what that edge sees
    task automatic sendWord(input instrWord word);
        int waited;
        waited = 0;
        if (!timedOut)
        begin
            @(negedge clk);
            instrValid = 1'b1;
            instr      = word;
            #1;
            while (!instrReady && waited < stallLimit)
            begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (!instrReady)
            begin
                errorCount++;
                timedOut = 1'b1;
                $display("timeout at %0t: instrReady stayed low for %0d cycles",
                         $time, stallLimit);
            end
            else
                modelAccept(word, edgeCount + 1);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            instrValid = 1'b0;
            instr      = instrWord'($urandom);   // ignored while valid is low
        end
    endtask

    task automatic checkIdle(input string phase);
        if (commitValid !== 1'b0 || instrReady !== 1'b1)
        begin
            errorCount++;
            $display("Mismatch at %0t: %s commitValid=%b instrReady=%b, expected 0 and 1",
                     $time, phase, commitValid, instrReady);
        end
    endtask

    // commit port is stable by the falling edge
    always @(negedge clk)
    begin
        if (nrst && commitValid)
        begin
            if (expRd.size() == 0)
            begin
                errorCount++;
                $display("unexpected commit to x%0d at %0t with nothing outstanding",
                         commitRd, $time);
            end
            else
            begin
                wantRd   = expRd.pop_front();
                wantData = expData.pop_front();
                wantEdge = expEdge.pop_front();
                commitCount++;
                if (commitRd !== wantRd || commitData !== wantData)
                begin
                    errorCount++;
                    $display("Mismatch at %0t: commit x%0d = %h, expected x%0d = %h",
                             $time, commitRd, commitData, wantRd, wantData);
                end
                // issue register loads on the accepting edge, commit one edge later
                if (edgeCount != wantEdge + 1)
                begin
                    errorCount++;
                    $display("Mismatch at %0t: commit x%0d after edge %0d, expected edge %0d",
                             $time, commitRd, edgeCount, wantEdge + 1);
                end
            end
        end
    end

    initial
    begin
        int waited;
        clk         = 1'b0;
        nrst        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        edgeCount   = 0;
        errorCount  = 0;
        commitCount = 0;
        timedOut    = 1'b0;
        for (int r = 0; r < 32; r++)
            archRegs[r] = '0;
        void'($urandom(32'hac6e_f1f0));

        repeat (5)
        begin
            @(negedge clk);
            checkIdle("during reset");
        end
        nrst = 1'b1;
        repeat (2)
        begin
            @(negedge clk);
            checkIdle("after reset");
        end

        // dependent chains build wide values in x1..x7
        for (int r = 1; r < 8; r++)
        begin
            sendWord(makeI(3'b000, randomImm(), 5'(r), 5'd0));
            sendWord(makeI(3'b001, 12'd12, 5'(r), 5'(r)));
            sendWord(makeI(3'b100, randomImm(), 5'(r), 5'(r)));
            sendWord(makeI(3'b001, 12'd9, 5'(r), 5'(r)));
            sendWord(makeI(3'b100, randomImm(), 5'(r), 5'(r)));
        end

        // x0 as target and source, then a dropped opcode
        sendWord(makeR(3'b000, 1'b0, 5'd0, 5'd1, 5'd2));
        sendWord(makeI(3'b000, 12'd5, 5'd0, 5'd3));
        sendWord(makeR(3'b000, 1'b0, 5'd4, 5'd0, 5'd1));
        sendWord(makeR(3'b000, 1'b1, 5'd5, 5'd0, 5'd2));
        sendWord(instrWord'({25'h1abcd3, 7'b1100011}));
        sendWord(makeR(3'b110, 1'b0, 5'd6, 5'd6, 5'd0));

        for (int n = 0; n < 400; n++)
        begin
            sendWord(randomWord());
            if ($urandom_range(4) == 0)
                idle(1 + $urandom_range(2));
        end
        idle(1);

        waited = 0;
        while (expRd.size() > 0 && waited < drainLimit)
        begin
            @(posedge clk);
            waited++;
        end
        if (expRd.size() > 0)
        begin
            errorCount++;
            $display("timeout at %0t: %0d expected commits never arrived",
                     $time, expRd.size());
        end
        repeat (4) @(posedge clk);   // room for a stray late commit

        $display("coreTb finished: %0d commits checked, %0d errors", commitCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/coreTop.sv
`default_nettype none

module coreTop import rvPkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        instrValid,
    input  instrWord    instr,
    output logic        instrReady,
    output logic        commitValid,
    output regAddr      commitRd,
    output logic [31:0] commitData
);

    // decoder to issue
    logic        decValid;
    regAddr      decRs1;
    regAddr      decRs2;
    regAddr      decRd;
    logic        decUsesRs2;
    aluOp        decAluFn;
    bSelect      decBSel;
    logic [31:0] decImmediate;
    logic        decWriteEnable;

    // issue to execute
    logic        stall;
    logic        exValid;
    regAddr      exRd;
    aluOp        exAluFn;
    logic [31:0] exOpA;
    logic [31:0] exOpB;
    logic        exWriteEnable;

    assign instrReady = !stall;

    instrDecoder instrDecoder_inst
    (
        .instrValid  (instrValid),
        .instr       (instr),
        .valid       (decValid),
        .rs1         (decRs1),
        .rs2         (decRs2),
        .rd          (decRd),
        .usesRs2     (decUsesRs2),
        .aluFn       (decAluFn),
        .bSel        (decBSel),
        .immediate   (decImmediate),
        .writeEnable (decWriteEnable)
    );

    issueStage issueStage_inst
    (
        .clk           (clk),
        .nrst          (nrst),
        .valid         (decValid),
        .rs1           (decRs1),
        .rs2           (decRs2),
        .rd            (decRd),
        .usesRs2       (decUsesRs2),
        .aluFn         (decAluFn),
        .bSel          (decBSel),
        .immediate     (decImmediate),
        .writeEnable   (decWriteEnable),
        .wbValid       (commitValid),   // commit doubles as writeback
        .wbRd          (commitRd),
        .wbData        (commitData),
        .stall         (stall),
        .exValid       (exValid),
        .exRd          (exRd),
        .exAluFn       (exAluFn),
        .exOpA         (exOpA),
        .exOpB         (exOpB),
        .exWriteEnable (exWriteEnable)
    );

    executeStage executeStage_inst
    (
        .clk           (clk),
        .nrst          (nrst),
        .exValid       (exValid),
        .exRd          (exRd),
        .exAluFn       (exAluFn),
        .exOpA         (exOpA),
        .exOpB         (exOpB),
        .exWriteEnable (exWriteEnable),
        .commitValid   (commitValid),
        .commitRd      (commitRd),
        .commitData    (commitData)
    );

endmodule

`default_nettype wire

//--- source/executeStage.sv
`default_nettype none

module executeStage import rvPkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        exValid,
    input  regAddr      exRd,
    input  aluOp        exAluFn,
    input  logic [31:0] exOpA,
    input  logic [31:0] exOpB,
    input  logic        exWriteEnable,
    output logic        commitValid,
    output regAddr      commitRd,
    output logic [31:0] commitData
);

    logic [31:0] aluResult;
    logic [4:0]  shamt;

    assign shamt = exOpB[4:0];  // only the low five bits shift

    always_comb
    begin
        case (exAluFn)
            aluAdd:  aluResult = exOpA + exOpB;
            aluSub:  aluResult = exOpA - exOpB;
            aluAnd:  aluResult = exOpA & exOpB;
            aluOr:   aluResult = exOpA | exOpB;
            aluXor:  aluResult = exOpA ^ exOpB;
            aluSll:  aluResult = exOpA << shamt;
            aluSrl:  aluResult = exOpA >> shamt;
            aluSra:  aluResult = $signed(exOpA) >>> shamt;
            aluSlt:  aluResult = {31'b0, $signed(exOpA) < $signed(exOpB)};
            aluSltu: aluResult = {31'b0, exOpA < exOpB};
            default: aluResult = '0;
        endcase
    end

    // commit register, also the writeback into the register file
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            commitValid <= 1'b0;
            commitRd    <= '0;
        end
        else
        begin
            commitValid <= exValid && exWriteEnable;
            commitRd    <= exRd;
        end
    end

    always_ff @(posedge clk)
    begin
        commitData <= aluResult;
    end

endmodule

`default_nettype wire

//--- source/issueStage.sv
`default_nettype none

module issueStage import rvPkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        valid,
    input  regAddr      rs1,
    input  regAddr      rs2,
    input  regAddr      rd,
    input  logic        usesRs2,
    input  aluOp        aluFn,
    input  bSelect      bSel,
    input  logic [31:0] immediate,
    input  logic        writeEnable,
    input  logic        wbValid,
    input  regAddr      wbRd,
    input  logic [31:0] wbData,
    output logic        stall,
    output logic        exValid,
    output regAddr      exRd,
    output aluOp        exAluFn,
    output logic [31:0] exOpA,
    output logic [31:0] exOpB,
    output logic        exWriteEnable
);

    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] opBReg;
    logic [31:0] immReg;
    bSelect      bSelReg;
    logic        issue;

    assign issue = valid && !stall;

    regFile regFile_inst
    (
        .clk       (clk),
        .nrst      (nrst),
        .we        (wbValid),
        .writeAddr (wbRd),
        .writeData (wbData),
        .sourceA   (rs1),
        .sourceB   (rs2),
        .opA       (operandA),
        .opB       (operandB)
    );

    hazardScoreboard hazardScoreboard_inst
    (
        .clk         (clk),
        .nrst        (nrst),
        .valid       (valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .usesRs2     (usesRs2),
        .rd          (rd),
        .writeEnable (writeEnable),
        .wbValid     (wbValid),
        .wbRd        (wbRd),
        .stall       (stall)
    );

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            exValid       <= 1'b0;
            exRd          <= '0;
            exAluFn       <= aluAdd;
            exWriteEnable <= 1'b0;
            bSelReg       <= bZero;
        end
        else if (issue)
        begin
            exValid       <= 1'b1;
            exRd          <= rd;
            exAluFn       <= aluFn;
            exWriteEnable <= writeEnable;
            bSelReg       <= bSel;
        end
        else
        begin
            // stall or dropped word, send a bubble down
            exValid       <= 1'b0;
            exRd          <= '0;
            exAluFn       <= aluAdd;
            exWriteEnable <= 1'b0;
            bSelReg       <= bZero;
        end
    end

    always_ff @(posedge clk)
    begin
        exOpA  <= operandA;
        opBReg <= operandB;
        immReg <= immediate;
    end

    // operand b picked after the pipe register
    always_comb
    begin
        case (bSelReg)
            bReg:    exOpB = opBReg;
            bImm:    exOpB = immReg;
            bShamt:  exOpB = {27'b0, immReg[4:0]};
            default: exOpB = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/hazardScoreboard.sv
`default_nettype none

module hazardScoreboard import rvPkg::*;
(
    input  logic   clk,
    input  logic   nrst,
    input  logic   valid,
    input  regAddr rs1,
    input  regAddr rs2,
    input  logic   usesRs2,
    input  regAddr rd,
    input  logic   writeEnable,
    input  logic   wbValid,
    input  regAddr wbRd,
    output logic   stall
);

    logic [31:0] pending;   // one bit per register still in flight
    logic [31:0] inFlight;  // writer now in execute, younger than the writeback
    logic [31:0] setMask;
    logic [31:0] clearMask;
    logic        busyA;
    logic        busyB;

    // a writeback frees its register only if no younger writer of it follows
    always_comb
    begin
        clearMask = '0;
        if (wbValid && !inFlight[wbRd])
            clearMask[wbRd] = 1'b1;
    end

    // a register cleared this cycle is already readable through the bypass
    assign busyA = pending[rs1] && !clearMask[rs1];
    assign busyB = usesRs2 && pending[rs2] && !clearMask[rs2];
    assign stall = valid && (busyA || busyB);

    always_comb
    begin
        setMask = '0;
        if (valid && writeEnable && !stall)
            setMask[rd] = 1'b1;
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pending  <= '0;
            inFlight <= '0;
        end
        else
        begin
            pending  <= (pending & ~clearMask) | setMask;   // set wins over clear
            inFlight <= setMask;
        end
    end

endmodule

`default_nettype wire

//--- source/regFile.sv
`default_nettype none

module regFile import rvPkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        we,
    input  regAddr      writeAddr,
    input  logic [31:0] writeData,
    input  regAddr      sourceA,
    input  regAddr      sourceB,
    output logic [31:0] opA,
    output logic [31:0] opB
);

    logic [31:0] regs [1:31];   // x0 has no storage

    // read with x0 forced to zero and the incoming write passed straight through
    function automatic logic [31:0] readPort(input regAddr src);
        logic [31:0] value;
        if (src == 5'd0)
            value = '0;
        else if (we && (writeAddr == src))
            value = writeData;
        else
            value = regs[src];
        return value;
    endfunction

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (writeAddr != 5'd0))
            regs[writeAddr] <= writeData;
    end

    always_comb
    begin
        opA = readPort(sourceA);
        opB = readPort(sourceB);
    end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`default_nettype none

module instrDecoder import rvPkg::*;
(
    input  logic        instrValid,
    input  instrWord    instr,
    output logic        valid,
    output regAddr      rs1,
    output regAddr      rs2,
    output regAddr      rd,
    output logic        usesRs2,
    output aluOp        aluFn,
    output bSelect      bSel,
    output logic [31:0] immediate,
    output logic        writeEnable
);

    logic isR;
    logic isI;

    assign isR = (instr.rView.opcode == opcodeOp);
    assign isI = (instr.iView.opcode == opcodeOpImm);

    // other opcodes are taken in but travel on as bubbles
    assign valid = instrValid && (isR || isI);

    assign rs1     = instr.rView.rs1;   // same bits in both views
    assign rs2     = instr.rView.rs2;
    assign rd      = instr.rView.rd;
    assign usesRs2 = isR;

    assign immediate   = {{20{instr.iView.imm12[11]}}, instr.iView.imm12};
    assign writeEnable = (isR || isI) && (rd != 5'd0);

    always_comb
    begin
        aluFn = aluAdd;
        bSel  = bZero;
        if (isR)
        begin
            bSel = bReg;
            case (instr.rView.funct3)
                3'b000: aluFn = instr.rView.funct7[5] ? aluSub : aluAdd;
                3'b001: aluFn = aluSll;
                3'b010: aluFn = aluSlt;
                3'b011: aluFn = aluSltu;
                3'b100: aluFn = aluXor;
                3'b101: aluFn = instr.rView.funct7[5] ? aluSra : aluSrl;
                3'b110: aluFn = aluOr;
                default: aluFn = aluAnd;
            endcase
        end
        else if (isI)
        begin
            bSel = bImm;
            case (instr.iView.funct3)
                3'b001:
                begin
                    aluFn = aluSll;
                    bSel  = bShamt;
                end
                3'b101:
                begin
                    // imm12[10] tells srai from srli
                    aluFn = instr.iView.imm12[10] ? aluSra : aluSrl;
                    bSel  = bShamt;
                end
                3'b010: aluFn = aluSlt;
                3'b011: aluFn = aluSltu;
                3'b100: aluFn = aluXor;
                3'b110: aluFn = aluOr;
                3'b111: aluFn = aluAnd;
                default: aluFn = aluAdd;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/rvPkg.sv
`default_nettype none

package rvPkg;

    // architectural register index, x0 to x31
    typedef logic [4:0] regAddr;

    // alu operation select, add sits at zero so a bubble decodes as add
    typedef enum logic [3:0]
    {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9
    } aluOp;

    typedef enum logic [1:0]
    {
        bReg   = 2'b00,     // rs2 from the register file
        bImm   = 2'b01,     // sign extended imm12
        bShamt = 2'b10,     // shift amount of an immediate shift
        bZero  = 2'b11
    } bSelect;

    localparam logic [6:0] opcodeOp    = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;

    typedef struct packed
    {
        logic [6:0] funct7;
        regAddr     rs2;
        regAddr     rs1;
        logic [2:0] funct3;
        regAddr     rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed
    {
        logic [11:0] imm12;
        regAddr      rs1;
        logic [2:0]  funct3;
        regAddr      rd;
        logic [6:0]  opcode;
    } iFields;

    // one instruction word, seen as R type or I type
    typedef union packed
    {
        rFields rView;
        iFields iView;
    } instrWord;

endpackage

`default_nettype wire
